// File: rtl/ps_bus_pkg.sv
/*
  Shared widths, channel structs and address map of the PS system bus.
  Widths are fixed by the processor GP port: 32-bit address and data, 12-bit ID.
  Only AXI3 single-beat accesses are served, so a length field is kept for checking.
*/
`default_nettype none

package ps_bus_pkg;

  ////////////////////
  // Widths
  ////////////////////
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_strb_t;
  typedef logic [11:0] axi_id_t;
  typedef logic [3:0]  axi_len_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [7:0]  led_t;
  typedef logic [15:0] gpio_t;
  // Offset inside one 1 MB region
  typedef logic [19:0] reg_ofs_t;

  // AXI response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  ////////////////////
  // System bus
  ////////////////////
  // wen and ren are single-cycle strobes, never both set
  typedef struct packed {
    bus_addr_t addr;
    bus_data_t wdata;
    bus_strb_t wstrb;
    logic      wen;
    logic      ren;
  } sys_req_t;

  // ack is a pulse, err qualified by ack
  typedef struct packed {
    bus_data_t rdata;
    logic      ack;
    logic      err;
  } sys_rsp_t;

  ////////////////////
  // AXI channels
  ////////////////////
  typedef struct packed {
    axi_id_t   id;
    bus_addr_t addr;
    axi_len_t  len;
  } axi_aw_t;

  typedef struct packed {
    axi_id_t   id;
    bus_addr_t addr;
    axi_len_t  len;
  } axi_ar_t;

  typedef struct packed {
    bus_data_t data;
    bus_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    bus_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  ////////////////////
  // Address map
  ////////////////////
  // Compared with addr[31:20]
  localparam logic [11:0] REG_REGION = 12'h400;

  localparam reg_ofs_t REG_OFS_ID     = 20'h00;
  localparam reg_ofs_t REG_OFS_LED    = 20'h04;
  localparam reg_ofs_t REG_OFS_GPIO_O = 20'h08;
  localparam reg_ofs_t REG_OFS_GPIO_T = 20'h0C;
  localparam reg_ofs_t REG_OFS_GPIO_I = 20'h10;

  localparam bus_data_t ID_VALUE     = 32'h5053_4200;
  // All pins tri-stated, i.e. inputs
  localparam gpio_t     GPIO_T_RESET = 16'hFFFF;

endpackage

`default_nettype wire

// File: rtl/axi_gp_slave.sv
/*
  Single-beat AXI3 slave bridging the GP master onto the system bus.
  One access in flight; B or R back-pressure stalls all channels.
  Nonzero AWLEN/ARLEN is answered SLVERR without a bus cycle.
*/
`timescale 1ns/10ps
`default_nettype none

module axi_gp_slave (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // AXI slave port
  input  ps_bus_pkg::axi_aw_t  aw_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  ps_bus_pkg::axi_w_t   w_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output ps_bus_pkg::axi_b_t   b_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  input  ps_bus_pkg::axi_ar_t  ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output ps_bus_pkg::axi_r_t   r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  // System bus master
  output ps_bus_pkg::sys_req_t req_o,
  input  ps_bus_pkg::sys_rsp_t rsp_i
);
  import ps_bus_pkg::*;

  typedef enum logic [2:0] {IDLE, WR_ISSUE, RD_ISSUE, WAIT_ACK, RESP} state_t;

  state_t    state_q;
  state_t    state_d;
  logic      aw_cap_q;
  logic      w_cap_q;
  logic      wr_q;
  logic      len_err_q;
  axi_id_t   id_q;
  bus_addr_t addr_q;
  bus_data_t wdata_q;
  bus_strb_t wstrb_q;
  bus_data_t rdata_q;
  logic      err_q;
  axi_resp_t resp_code;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic aw_done;
  logic w_done;
  logic wr_len_err;
  logic resp_hs;
  logic leave_idle;

  ////////////////////
  // Handshakes
  ////////////////////
  // Each write beat taken once, then its ready drops
  assign aw_ready_o = (state_q == IDLE) && !aw_cap_q;
  assign w_ready_o  = (state_q == IDLE) && !w_cap_q;
  // Reads only when no write is started or offered
  assign ar_ready_o = (state_q == IDLE) && !aw_cap_q && !w_cap_q && !aw_valid_i && !w_valid_i;

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign ar_hs = ar_valid_i && ar_ready_o;

  // Beats captured by the end of this cycle
  assign aw_done = aw_cap_q || aw_hs;
  // Burst data is drained until the last beat
  assign w_done  = w_cap_q || (w_hs && w_i.last);

  assign wr_len_err = aw_hs ? (aw_i.len != '0) : len_err_q;
  assign resp_hs    = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i);
  assign leave_idle = (state_q == IDLE) && (state_d != IDLE);

  ////////////////////
  // FSM
  ////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (aw_done && w_done) begin
          state_d = wr_len_err ? RESP : WR_ISSUE;
        end else if (ar_hs) begin
          state_d = (ar_i.len != '0) ? RESP : RD_ISSUE;
        end
      end
      WR_ISSUE, RD_ISSUE: state_d = WAIT_ACK;
      WAIT_ACK: begin
        if (rsp_i.ack) begin
          state_d = RESP;
        end
      end
      RESP: begin
        if (resp_hs) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      aw_cap_q  <= 1'b0;
      w_cap_q   <= 1'b0;
      wr_q      <= 1'b0;
      len_err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (leave_idle) begin
        aw_cap_q <= 1'b0;
        w_cap_q  <= 1'b0;
        // Write or read decides B vs R
        wr_q     <= aw_done && w_done;
      end else begin
        if (aw_hs) begin
          aw_cap_q <= 1'b1;
        end
        if (w_hs && w_i.last) begin
          w_cap_q <= 1'b1;
        end
      end
      if (aw_hs) begin
        len_err_q <= (aw_i.len != '0);
      end
    end
  end

  // Access payload and response data
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q   <= aw_i.id;
      addr_q <= aw_i.addr;
    end else if (ar_hs) begin
      id_q   <= ar_i.id;
      addr_q <= ar_i.addr;
    end
    if (w_hs && w_i.last) begin
      wdata_q <= w_i.data;
      wstrb_q <= w_i.strb;
    end
    if ((state_q == WAIT_ACK) && rsp_i.ack) begin
      rdata_q <= rsp_i.rdata;
      err_q   <= rsp_i.err;
    end else if (leave_idle && (state_d == RESP)) begin
      // Burst rejected, no bus cycle
      rdata_q <= '0;
      err_q   <= 1'b1;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////
  always_comb begin
    req_o.addr  = addr_q;
    req_o.wdata = wdata_q;
    req_o.wstrb = wstrb_q;
    req_o.wen   = (state_q == WR_ISSUE);
    req_o.ren   = (state_q == RD_ISSUE);
  end

  assign resp_code = err_q ? RESP_SLVERR : RESP_OKAY;

  assign b_valid_o = (state_q == RESP) && wr_q;
  assign r_valid_o = (state_q == RESP) && !wr_q;

  assign b_o = '{id: id_q, resp: resp_code};
  assign r_o = '{id: id_q, data: rdata_q, resp: resp_code, last: 1'b1};

  // Strobes exclusive on the system bus
  assert property (@(posedge clk_i) disable iff (rst_i) !(req_o.wen && req_o.ren));

  // B held until accepted
  assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_o && !b_ready_i |=> b_valid_o);

  assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_o && !b_ready_i |=> $stable(b_o));

endmodule

`default_nettype wire

// File: rtl/sys_bus_decoder.sv
/*
  Registered system bus decoder, one cycle on the request path.
  Only REG_REGION is mapped; any other region is acked with err and zero data.
  Responses from the register bank pass back combinationally.
*/
`timescale 1ns/10ps
`default_nettype none

module sys_bus_decoder (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // From the AXI bridge
  input  ps_bus_pkg::sys_req_t req_i,
  output ps_bus_pkg::sys_rsp_t rsp_o,
  // To the register bank
  output ps_bus_pkg::sys_req_t reg_req_o,
  input  ps_bus_pkg::sys_rsp_t reg_rsp_i
);
  import ps_bus_pkg::*;

  bus_addr_t addr_q;
  bus_data_t wdata_q;
  bus_strb_t wstrb_q;
  logic      wen_q;
  logic      ren_q;
  logic      hit;
  logic      miss_ack;

  ////////////////////
  // Request register
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wen_q <= 1'b0;
      ren_q <= 1'b0;
    end else begin
      wen_q <= req_i.wen;
      ren_q <= req_i.ren;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q  <= req_i.addr;
    wdata_q <= req_i.wdata;
    wstrb_q <= req_i.wstrb;
  end

  // Region select on the top 12 address bits
  assign hit = (addr_q[31:20] == REG_REGION);

  always_comb begin
    reg_req_o.addr  = addr_q;
    reg_req_o.wdata = wdata_q;
    reg_req_o.wstrb = wstrb_q;
    reg_req_o.wen   = wen_q && hit;
    reg_req_o.ren   = ren_q && hit;
  end

  ////////////////////
  // Response path
  ////////////////////
  // Unmapped access answered locally, same cycle as the registered strobe
  assign miss_ack = (wen_q || ren_q) && !hit;

  always_comb begin
    rsp_o.rdata = miss_ack ? '0 : reg_rsp_i.rdata;
    rsp_o.ack   = reg_rsp_i.ack || miss_ack;
    rsp_o.err   = miss_ack || (reg_rsp_i.ack && reg_rsp_i.err);
  end

  // Ack one cycle after a miss strobe or two after a mapped one
  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_o.ack |-> $past(req_i.wen || req_i.ren) || $past(req_i.wen || req_i.ren, 2));

endmodule

`default_nettype wire

// File: rtl/gpio_led_regs.sv
/*
  LED and GPIO register bank, ack one cycle after each strobe.
  ID and GPIO_I are read-only; unknown offsets read zero without err.
  gpio_i is asynchronous and goes through a two-flop synchronizer.
*/
`timescale 1ns/10ps
`default_nettype none

module gpio_led_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  ps_bus_pkg::sys_req_t req_i,
  output ps_bus_pkg::sys_rsp_t rsp_o,
  // Pins
  input  ps_bus_pkg::gpio_t    gpio_i,
  output ps_bus_pkg::led_t     led_o,
  output ps_bus_pkg::gpio_t    gpio_o,
  output ps_bus_pkg::gpio_t    gpio_t_o
);
  import ps_bus_pkg::*;

  led_t      led_q;
  gpio_t     gpio_o_q;
  gpio_t     gpio_t_q;
  gpio_t     gpio_meta_q;
  gpio_t     gpio_sync_q;
  reg_ofs_t  ofs;
  bus_data_t rd_data;
  bus_data_t rdata_q;
  logic      ack_q;

  // Byte lanes replaced where the strobe is set
  function automatic bus_data_t lane_merge(bus_data_t old, bus_data_t wd, bus_strb_t st);
    bus_data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (st[i]) begin
        res[i*8 +: 8] = wd[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign ofs = req_i.addr[19:0];

  ////////////////////
  // GPIO input sync
  ////////////////////
  always_ff @(posedge clk_i) begin
    gpio_meta_q <= gpio_i;
    gpio_sync_q <= gpio_meta_q;
  end

  ////////////////////
  // Write side
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      led_q    <= '0;
      gpio_o_q <= '0;
      gpio_t_q <= GPIO_T_RESET;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= req_i.wen || req_i.ren;
      if (req_i.wen) begin
        // Writes to ID and GPIO_I fall to default
        case (ofs)
          REG_OFS_LED:
            led_q <= led_t'(lane_merge(bus_data_t'(led_q), req_i.wdata, req_i.wstrb));
          REG_OFS_GPIO_O:
            gpio_o_q <= gpio_t'(lane_merge(bus_data_t'(gpio_o_q), req_i.wdata, req_i.wstrb));
          REG_OFS_GPIO_T:
            gpio_t_q <= gpio_t'(lane_merge(bus_data_t'(gpio_t_q), req_i.wdata, req_i.wstrb));
          default: ;
        endcase
      end
    end
  end

  ////////////////////
  // Read side
  ////////////////////
  always_comb begin
    case (ofs)
      REG_OFS_ID:     rd_data = ID_VALUE;
      REG_OFS_LED:    rd_data = bus_data_t'(led_q);
      REG_OFS_GPIO_O: rd_data = bus_data_t'(gpio_o_q);
      REG_OFS_GPIO_T: rd_data = bus_data_t'(gpio_t_q);
      REG_OFS_GPIO_I: rd_data = bus_data_t'(gpio_sync_q);
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.ren) begin
      rdata_q <= rd_data;
    end
  end

  // Write ack carries no data
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = 1'b0;

  assign led_o    = led_q;
  assign gpio_o   = gpio_o_q;
  assign gpio_t_o = gpio_t_q;

endmodule

`default_nettype wire

// File: rtl/ps_bus_top.sv
/*
  PL side of the PS wrapper: AXI bridge, decoder, register bank.
  All ports in the clk_i domain except gpio_i.
*/
`timescale 1ns/10ps
`default_nettype none

module ps_bus_top (
  input  logic                clk_i,
  input  logic                rst_i,
  // AXI GP slave port
  input  ps_bus_pkg::axi_aw_t aw_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  ps_bus_pkg::axi_w_t  w_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  output ps_bus_pkg::axi_b_t  b_o,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  input  ps_bus_pkg::axi_ar_t ar_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output ps_bus_pkg::axi_r_t  r_o,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  // Pins
  input  ps_bus_pkg::gpio_t   gpio_i,
  output ps_bus_pkg::led_t    led_o,
  output ps_bus_pkg::gpio_t   gpio_o,
  output ps_bus_pkg::gpio_t   gpio_t_o
);
  import ps_bus_pkg::*;

  // Bridge to decoder
  sys_req_t sys_req;
  sys_rsp_t sys_rsp;
  // Decoder to register bank
  sys_req_t reg_req;
  sys_rsp_t reg_rsp;

  axi_gp_slave u_axi_gp_slave (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .aw_i       (aw_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_i        (w_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .b_o        (b_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .ar_i       (ar_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_o        (r_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .req_o      (sys_req),
    .rsp_i      (sys_rsp)
  );

  sys_bus_decoder u_sys_bus_decoder (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (sys_req),
    .rsp_o     (sys_rsp),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  gpio_led_regs u_gpio_led_regs (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (reg_req),
    .rsp_o    (reg_rsp),
    .gpio_i   (gpio_i),
    .led_o    (led_o),
    .gpio_o   (gpio_o),
    .gpio_t_o (gpio_t_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
/*
  Clock and reset for the testbench.
  100 ns period; reset high for the first 8 rising edges, released 1 ns after.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  // Synchronous reset, dropped just after an edge
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: verif/tb_ps_bus.sv
/*
  Directed tests for ps_bus_top through its AXI GP slave port.
  Inputs change 1 ns after the rising edge; outputs are sampled mid-cycle.
  gpio_i is held constant while the random traffic runs.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_ps_bus;
  import ps_bus_pkg::*;

  localparam int          NUM_TESTS   = 6;
  localparam int          NUM_RANDOM  = 40;
  localparam int          WAIT_LIMIT  = 200;
  localparam longint      WATCHDOG_NS = longint'(NUM_TESTS) * 2000 * 100;
  localparam logic [31:0] SEED        = 32'h8347_6023;

  logic    clk;
  logic    rst;
  axi_aw_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w_beat;
  logic    w_valid;
  logic    w_ready;
  axi_b_t  b_out;
  logic    b_valid;
  logic    b_ready;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_r_t  r_out;
  logic    r_valid;
  logic    r_ready;
  gpio_t   gpio_in;
  led_t    led;
  gpio_t   gpio_out;
  gpio_t   gpio_tri;

  // Expected register contents
  led_t        exp_led;
  gpio_t       exp_gpio_o;
  gpio_t       exp_gpio_t;
  logic [31:0] lfsr_q;
  int          errors;
  int          tests_failed;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  ps_bus_top uut (
    .clk_i      (clk),
    .rst_i      (rst),
    .aw_i       (aw),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .w_i        (w_beat),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .b_o        (b_out),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .ar_i       (ar),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .r_o        (r_out),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .gpio_i     (gpio_in),
    .led_o      (led),
    .gpio_o     (gpio_out),
    .gpio_t_o   (gpio_tri)
  );

  ////////////////////
  // Random source
  ////////////////////
  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic rand_id(output axi_id_t id);
    logic [31:0] v;
    rand_bits(12, v);
    id = v[11:0];
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  function automatic bus_addr_t reg_addr(reg_ofs_t ofs);
    return {REG_REGION, ofs};
  endfunction

  // Whole byte lanes taken from the new word where strobed
  function automatic bus_data_t strobe_update(bus_data_t cur, bus_data_t wd, bus_strb_t st);
    bus_data_t mask;
    mask = {{8{st[3]}}, {8{st[2]}}, {8{st[1]}}, {8{st[0]}}};
    return (cur & ~mask) | (wd & mask);
  endfunction

  function automatic reg_ofs_t pick_ofs(logic [2:0] k);
    case (k)
      3'd0:    return REG_OFS_ID;
      3'd2:    return REG_OFS_GPIO_O;
      3'd3:    return REG_OFS_GPIO_T;
      3'd4:    return REG_OFS_GPIO_I;
      3'd5:    return 20'h14;
      default: return REG_OFS_LED;
    endcase
  endfunction

  task automatic model_write(input bus_addr_t a, input bus_data_t d, input bus_strb_t st,
                             input axi_len_t len, output axi_resp_t resp);
    resp = RESP_SLVERR;
    if (a[31:20] == REG_REGION && len == 0) begin
      resp = RESP_OKAY;
      case (a[19:0])
        REG_OFS_LED:    exp_led    = led_t'(strobe_update(32'(exp_led), d, st));
        REG_OFS_GPIO_O: exp_gpio_o = gpio_t'(strobe_update(32'(exp_gpio_o), d, st));
        REG_OFS_GPIO_T: exp_gpio_t = gpio_t'(strobe_update(32'(exp_gpio_t), d, st));
        default: ;
      endcase
    end
  endtask

  task automatic model_read(input bus_addr_t a, input axi_len_t len,
                            output bus_data_t d, output axi_resp_t resp);
    d    = '0;
    resp = RESP_SLVERR;
    if (a[31:20] == REG_REGION && len == 0) begin
      resp = RESP_OKAY;
      case (a[19:0])
        REG_OFS_ID:     d = ID_VALUE;
        REG_OFS_LED:    d = 32'(exp_led);
        REG_OFS_GPIO_O: d = 32'(exp_gpio_o);
        REG_OFS_GPIO_T: d = 32'(exp_gpio_t);
        REG_OFS_GPIO_I: d = 32'(gpio_in);
        default:        d = '0;
      endcase
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////
  task automatic check_eq(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_pins;
    check_eq("led_o", led, exp_led);
    check_eq("gpio_o", gpio_out, exp_gpio_o);
    check_eq("gpio_t_o", gpio_tri, exp_gpio_t);
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  ////////////////////
  // AXI driver
  ////////////////////
  // Order 0 or 1 sends AW and W together, 2 sends AW first, 3 sends W first
  task automatic send_write_beats(input axi_aw_t a_beat, input axi_w_t d_beat);
    logic [31:0] order;
    logic        aw_todo;
    logic        w_todo;
    logic        aw_fire;
    logic        w_fire;
    int          cycles;
    rand_bits(2, order);
    aw_todo  = 1'b1;
    w_todo   = 1'b1;
    cycles   = 0;
    aw       = a_beat;
    w_beat   = d_beat;
    aw_valid = (order != 3);
    w_valid  = (order != 2);
    while ((aw_todo || w_todo) && cycles < WAIT_LIMIT) begin
      #49;
      aw_fire = aw_valid && aw_ready;
      w_fire  = w_valid && w_ready;
      next_cycle();
      cycles++;
      if (aw_fire) begin
        aw_valid = 1'b0;
        aw_todo  = 1'b0;
      end
      if (w_fire) begin
        w_valid = 1'b0;
        w_todo  = 1'b0;
      end
      // Second beat follows once the first is taken
      aw_valid = aw_valid || (aw_todo && !w_todo);
      w_valid  = w_valid || (w_todo && !aw_todo);
    end
    if (aw_todo || w_todo) begin
      $display("Timeout at %0t ns: write address or data beat never accepted", $time);
      errors++;
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end
  endtask

  // Waits for B or R, stalls ready a random 0..3 cycles and watches the channel hold
  task automatic collect_response(input logic is_read, output logic [63:0] payload);
    logic [31:0] delay;
    logic [63:0] held;
    logic [63:0] cur;
    int          cycles;
    cycles  = 0;
    payload = '0;
    rand_bits(2, delay);
    while (cycles < WAIT_LIMIT) begin
      #49;
      if (is_read ? r_valid : b_valid) begin
        break;
      end
      next_cycle();
      cycles++;
    end
    if (cycles >= WAIT_LIMIT) begin
      $display("Timeout at %0t ns: no %s response from the DUT", $time, is_read ? "R" : "B");
      errors++;
      return;
    end
    if (is_read) begin
      held = r_out;
    end else begin
      held = b_out;
    end
    for (int i = 0; i < delay; i++) begin
      @(posedge clk);
      #50;
      if (is_read) begin
        cur = r_out;
      end else begin
        cur = b_out;
      end
      check_eq(is_read ? "r_valid_o" : "b_valid_o", is_read ? r_valid : b_valid, 1'b1);
      check_eq(is_read ? "r_o" : "b_o", cur, held);
    end
    next_cycle();
    r_ready = is_read;
    b_ready = !is_read;
    next_cycle();
    r_ready = 1'b0;
    b_ready = 1'b0;
    payload = held;
  endtask

  task automatic axi_write(input axi_id_t id, input bus_addr_t a, input bus_data_t d,
                           input bus_strb_t st, input axi_len_t len);
    axi_aw_t     a_beat;
    axi_w_t      d_beat;
    axi_b_t      b;
    axi_resp_t   exp_resp;
    logic [63:0] payload;
    a_beat.id   = id;
    a_beat.addr = a;
    a_beat.len  = len;
    d_beat.data = d;
    d_beat.strb = st;
    d_beat.last = 1'b1;
    send_write_beats(a_beat, d_beat);
    collect_response(1'b0, payload);
    b = payload[$bits(axi_b_t)-1:0];
    model_write(a, d, st, len, exp_resp);
    check_eq("b_o.id", b.id, id);
    check_eq("b_o.resp", b.resp, exp_resp);
    check_pins();
  endtask

  task automatic axi_read(input axi_id_t id, input bus_addr_t a, input axi_len_t len);
    axi_r_t      r;
    bus_data_t   exp_data;
    axi_resp_t   exp_resp;
    logic [63:0] payload;
    int          cycles;
    cycles   = 0;
    ar.id    = id;
    ar.addr  = a;
    ar.len   = len;
    ar_valid = 1'b1;
    while (cycles < WAIT_LIMIT) begin
      #49;
      if (ar_ready) begin
        break;
      end
      next_cycle();
      cycles++;
    end
    next_cycle();
    ar_valid = 1'b0;
    if (cycles >= WAIT_LIMIT) begin
      $display("Timeout at %0t ns: read address beat never accepted", $time);
      errors++;
      return;
    end
    collect_response(1'b1, payload);
    r = payload[$bits(axi_r_t)-1:0];
    model_read(a, len, exp_data, exp_resp);
    check_eq("r_o.id", r.id, id);
    check_eq("r_o.data", r.data, exp_data);
    check_eq("r_o.resp", r.resp, exp_resp);
    check_eq("r_o.last", r.last, 1'b1);
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic finish_test(input string name, input int start);
    if (errors == start) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - start);
      tests_failed++;
    end
  endtask

  task automatic test_reset_values;
    int      start;
    axi_id_t id;
    start = errors;
    check_eq("b_valid_o", b_valid, 1'b0);
    check_eq("r_valid_o", r_valid, 1'b0);
    check_eq("aw_ready_o", aw_ready, 1'b1);
    check_eq("w_ready_o", w_ready, 1'b1);
    check_eq("ar_ready_o", ar_ready, 1'b1);
    check_pins();
    rand_id(id);
    axi_read(id, reg_addr(REG_OFS_ID), 4'd0);
    finish_test("reset_values", start);
  endtask

  // Full-word writes then read back, IDs echoed
  task automatic test_full_writes;
    int          start;
    axi_id_t     id;
    logic [31:0] d;
    start = errors;
    for (int k = 1; k <= 3; k++) begin
      rand_id(id);
      rand_bits(32, d);
      axi_write(id, reg_addr(pick_ofs(3'(k))), d, 4'hF, 4'd0);
      rand_id(id);
      axi_read(id, reg_addr(pick_ofs(3'(k))), 4'd0);
    end
    finish_test("full_writes", start);
  endtask

  // Byte lanes, plus writes to the read-only registers
  task automatic test_partial_writes;
    int          start;
    axi_id_t     id;
    logic [31:0] d;
    logic [31:0] st;
    logic [31:0] k;
    start = errors;
    for (int i = 0; i < 8; i++) begin
      rand_bits(2, k);
      rand_bits(4, st);
      rand_bits(32, d);
      rand_id(id);
      axi_write(id, reg_addr(pick_ofs(3'(k % 3 + 1))), d, st[3:0], 4'd0);
      axi_read(id, reg_addr(pick_ofs(3'(k % 3 + 1))), 4'd0);
    end
    axi_write(12'h0A1, reg_addr(REG_OFS_ID), 32'hFFFF_FFFF, 4'hF, 4'd0);
    axi_read(12'h0A2, reg_addr(REG_OFS_ID), 4'd0);
    axi_write(12'h0A3, reg_addr(REG_OFS_GPIO_I), 32'hFFFF_FFFF, 4'hF, 4'd0);
    axi_read(12'h0A4, reg_addr(REG_OFS_GPIO_I), 4'd0);
    finish_test("partial_writes", start);
  endtask

  // Synchronizer needs a few idle cycles before the read
  task automatic test_gpio_input;
    int          start;
    axi_id_t     id;
    logic [31:0] v;
    start = errors;
    for (int i = 0; i < 3; i++) begin
      rand_bits(16, v);
      gpio_in = v[15:0];
      repeat (3) next_cycle();
      rand_id(id);
      axi_read(id, reg_addr(REG_OFS_GPIO_I), 4'd0);
    end
    finish_test("gpio_input", start);
  endtask

  // Unmapped regions and bursts
  task automatic test_error_responses;
    int start;
    start = errors;
    axi_read(12'h101, 32'h8000_0004, 4'd0);
    axi_write(12'h102, 32'h8000_0004, 32'h1234_5678, 4'hF, 4'd0);
    axi_read(12'h103, 32'h4010_0004, 4'd0);
    axi_write(12'h104, 32'h4010_0008, 32'hFFFF_FFFF, 4'hF, 4'd0);
    axi_write(12'h105, reg_addr(REG_OFS_LED), 32'h0000_005A, 4'hF, 4'd3);
    axi_write(12'h106, reg_addr(REG_OFS_GPIO_O), 32'h0000_C3C3, 4'h3, 4'd1);
    axi_read(12'h107, reg_addr(REG_OFS_LED), 4'd1);
    axi_read(12'h108, reg_addr(REG_OFS_LED), 4'd0);
    axi_read(12'h109, reg_addr(REG_OFS_GPIO_O), 4'd0);
    finish_test("error_responses", start);
  endtask

  task automatic test_random_traffic;
    int          start;
    axi_id_t     id;
    bus_addr_t   a;
    logic [31:0] k;
    logic [31:0] m;
    logic [31:0] d;
    logic [31:0] st;
    logic [31:0] rw;
    axi_len_t    len;
    start = errors;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rand_bits(3, k);
      rand_bits(3, m);
      rand_bits(1, rw);
      rand_bits(32, d);
      rand_bits(4, st);
      rand_id(id);
      // About one in eight misses the region, as many are bursts
      a   = (m == 0) ? {12'h800, pick_ofs(k[2:0])} : reg_addr(pick_ofs(k[2:0]));
      len = (m == 7) ? 4'd2 : 4'd0;
      if (rw[0]) begin
        axi_write(id, a, d, st[3:0], len);
      end else begin
        axi_read(id, a, len);
      end
    end
    finish_test("random_traffic", start);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    lfsr_q       = SEED;
    errors       = 0;
    tests_failed = 0;
    aw           = '0;
    aw_valid     = 1'b0;
    w_beat       = '0;
    w_valid      = 1'b0;
    b_ready      = 1'b0;
    ar           = '0;
    ar_valid     = 1'b0;
    r_ready      = 1'b0;
    gpio_in      = '0;
    exp_led      = '0;
    exp_gpio_o   = '0;
    exp_gpio_t   = GPIO_T_RESET;
    @(negedge rst);
    next_cycle();
    test_reset_values();
    test_full_writes();
    test_partial_writes();
    test_gpio_input();
    test_error_responses();
    test_random_traffic();
    $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog, 2000 cycles per test
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns, the tests did not complete", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/ps_bus_pkg.sv
rtl/axi_gp_slave.sv
rtl/sys_bus_decoder.sv
rtl/gpio_led_regs.sv
rtl/ps_bus_top.sv
verif/tb_clk_gen.sv
verif/tb_ps_bus.sv

// File: Bender.yml
package:
  name: ps_bus

sources:
  - files:
      - rtl/ps_bus_pkg.sv
      - rtl/axi_gp_slave.sv
      - rtl/sys_bus_decoder.sv
      - rtl/gpio_led_regs.sv
      - rtl/ps_bus_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_ps_bus.sv
